/* source/decode_pkg.sv */
// RV32IM decode definitions
`default_nettype none

package decode_pkg;

  ////////////////////////////////////////
  // instruction encodings
  ////////////////////////////////////////

  // major opcodes in bits 6:0 of the word
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_I      = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_R      = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // one entry per recognised instruction
  typedef enum logic [5:0] {
    K_NONE,
    K_ADD, K_SUB, K_SLL, K_SLT, K_SLTU, K_XOR, K_SRL, K_SRA, K_OR, K_AND,
    K_ADDI, K_SLTI, K_SLTIU, K_XORI, K_ORI, K_ANDI, K_SLLI, K_SRLI, K_SRAI,
    K_MUL, K_MULH, K_MULHSU, K_MULHU, K_DIV, K_DIVU, K_REM, K_REMU,
    K_LB, K_LH, K_LW, K_LBU, K_LHU,
    K_SB, K_SH, K_SW,
    K_BEQ, K_BNE, K_BLT, K_BGE, K_BLTU, K_BGEU,
    K_LUI, K_AUIPC, K_JAL, K_JALR,
    K_ECALL, K_EBREAK
  } inst_kind_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } inst_t;

  ////////////////////////////////////////
  // datapath controls
  ////////////////////////////////////////

  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    OP_LUI
  } alu_op_e;

  typedef enum logic [3:0] {
    NO_BJ, BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR
  } pc_sel_e;

  typedef enum logic [2:0] {
    NO_IMM, I_IMM, I_USIMM, S_IMM, B_IMM, U_IMM, J_IMM
  } imm_sel_e;

  // first ALU operand source
  typedef enum logic [1:0] {
    IN1_RS1, IN1_PC_JALR, IN1_PC
  } in1_sel_e;

  typedef enum logic [1:0] {
    RES_ALU, RES_MEM, RES_PC4
  } result_src_e;

  typedef enum logic [1:0] {
    NO_SIZE, BYTE, HALF_WORD, WORD
  } rw_size_e;

  typedef enum logic [1:0] {
    NO_EXCEPTION, ECALL, EBREAK, ILLEGAL_INSTRUCTION
  } exc_e;

  typedef struct packed {
    alu_op_e     alu_op;
    pc_sel_e     pc_sel;
    imm_sel_e    imm_sel;
    in1_sel_e    in1_sel;
    logic        in2_imm;
    result_src_e result_src;
    rw_size_e    rw_size;
    logic        ld_sign;
    logic        rf_wr_en;
    logic        mem_wr_en;
    exc_e        exc;
  } ctrl_t;

  // default row is a bubble with no side effects
  localparam ctrl_t CTRL_IDLE = '{
    alu_op:     OP_ADD,
    pc_sel:     NO_BJ,
    imm_sel:    NO_IMM,
    in1_sel:    IN1_RS1,
    in2_imm:    1'b0,
    result_src: RES_ALU,
    rw_size:    NO_SIZE,
    ld_sign:    1'b0,
    rf_wr_en:   1'b0,
    mem_wr_en:  1'b0,
    exc:        NO_EXCEPTION
  };

endpackage

`default_nettype wire

/* source/decode_ctrl_if.sv */
// Decoded control bundle
`timescale 1ns/1ps
`default_nettype none

interface decode_ctrl_if;
  import decode_pkg::*;

  alu_op_e     alu_op;
  pc_sel_e     pc_sel;
  imm_sel_e    imm_sel;
  in1_sel_e    in1_sel;
  logic        in2_imm;
  result_src_e result_src;
  rw_size_e    rw_size;
  logic        ld_sign;
  logic        rf_wr_en;
  logic        mem_wr_en;
  exc_e        exc;

  // each decoder owns a slice of the bundle
  modport classify (output exc);
  modport alu (output alu_op);
  modport datapath (
    output pc_sel, imm_sel, in1_sel, in2_imm, result_src,
    output rw_size, ld_sign, rf_wr_en, mem_wr_en
  );
  modport stage (
    input alu_op, pc_sel, imm_sel, in1_sel, in2_imm, result_src,
    input rw_size, ld_sign, rf_wr_en, mem_wr_en, exc
  );

endinterface

`default_nettype wire

/* source/inst_classify.sv */
// Instruction classifier
`timescale 1ns/1ps
`default_nettype none

module inst_classify (
  input  decode_pkg::inst_t      inst_i,
  output decode_pkg::inst_kind_e kind_o,
  decode_ctrl_if.classify        ctrl
);
  import decode_pkg::*;

  logic       f7_alt;
  logic       f7_mul;
  inst_kind_e kind;

  // funct7[5] picks sub/sra while funct7[0] is bit 25 and selects RV32M
  assign f7_alt = inst_i.funct7[5];
  assign f7_mul = inst_i.funct7[0];

  always_comb begin
    kind = K_NONE;
    case (inst_i.opcode)
      OPC_R: begin
        if (f7_mul && !f7_alt) begin
          case (inst_i.funct3)
            3'd0:    kind = K_MUL;
            3'd1:    kind = K_MULH;
            3'd2:    kind = K_MULHSU;
            3'd3:    kind = K_MULHU;
            3'd4:    kind = K_DIV;
            3'd5:    kind = K_DIVU;
            3'd6:    kind = K_REM;
            default: kind = K_REMU;
          endcase
        end else if (!f7_mul) begin
          case ({f7_alt, inst_i.funct3})
            4'b0_000: kind = K_ADD;
            4'b1_000: kind = K_SUB;
            4'b0_001: kind = K_SLL;
            4'b0_010: kind = K_SLT;
            4'b0_011: kind = K_SLTU;
            4'b0_100: kind = K_XOR;
            4'b0_101: kind = K_SRL;
            4'b1_101: kind = K_SRA;
            4'b0_110: kind = K_OR;
            4'b0_111: kind = K_AND;
            default:  kind = K_NONE;
          endcase
        end
      end
      OPC_I: begin
        case (inst_i.funct3)
          3'd0:    kind = K_ADDI;
          3'd1:    kind = K_SLLI;
          3'd2:    kind = K_SLTI;
          3'd3:    kind = K_SLTIU;
          3'd4:    kind = K_XORI;
          3'd5:    kind = f7_alt ? K_SRAI : K_SRLI;
          3'd6:    kind = K_ORI;
          default: kind = K_ANDI;
        endcase
      end
      OPC_LOAD: begin
        case (inst_i.funct3)
          3'd0:    kind = K_LB;
          3'd1:    kind = K_LH;
          3'd2:    kind = K_LW;
          3'd4:    kind = K_LBU;
          3'd5:    kind = K_LHU;
          default: kind = K_NONE;
        endcase
      end
      OPC_STORE: begin
        case (inst_i.funct3)
          3'd0:    kind = K_SB;
          3'd1:    kind = K_SH;
          3'd2:    kind = K_SW;
          default: kind = K_NONE;
        endcase
      end
      OPC_BRANCH: begin
        case (inst_i.funct3)
          3'd0:    kind = K_BEQ;
          3'd1:    kind = K_BNE;
          3'd4:    kind = K_BLT;
          3'd5:    kind = K_BGE;
          3'd6:    kind = K_BLTU;
          3'd7:    kind = K_BGEU;
          default: kind = K_NONE;
        endcase
      end
      OPC_LUI:   kind = K_LUI;
      OPC_AUIPC: kind = K_AUIPC;
      OPC_JAL:   kind = K_JAL;
      OPC_JALR:  kind = K_JALR;
      OPC_SYSTEM: begin
        // word bits 21:20 tell ecall from ebreak
        case (inst_i.rs2[1:0])
          2'd0:    kind = K_ECALL;
          2'd1:    kind = K_EBREAK;
          default: kind = K_NONE;
        endcase
      end
      default: kind = K_NONE;
    endcase
  end

  always_comb begin
    case (kind)
      K_ECALL:                ctrl.exc = ECALL;
      K_EBREAK:               ctrl.exc = EBREAK;
      // shamt is 5 bits on RV32 so bit 25 must be clear
      K_SLLI, K_SRLI, K_SRAI: ctrl.exc = f7_mul ? ILLEGAL_INSTRUCTION : NO_EXCEPTION;
      default:                ctrl.exc = NO_EXCEPTION;
    endcase
  end

  assign kind_o = kind;

endmodule

`default_nettype wire

/* source/alu_op_decode.sv */
// ALU operation decoder
`timescale 1ns/1ps
`default_nettype none

module alu_op_decode (
  input  decode_pkg::inst_kind_e kind_i,
  decode_ctrl_if.alu             ctrl
);
  import decode_pkg::*;

  always_comb begin
    case (kind_i)
      ////////////////////////////////////////
      // base integer, register and imm forms
      ////////////////////////////////////////
      K_ADD, K_ADDI:   ctrl.alu_op = OP_ADD;
      K_SUB:           ctrl.alu_op = OP_SUB;
      K_SLL, K_SLLI:   ctrl.alu_op = OP_SLL;
      K_SLT, K_SLTI:   ctrl.alu_op = OP_SLT;
      K_SLTU, K_SLTIU: ctrl.alu_op = OP_SLTU;
      K_XOR, K_XORI:   ctrl.alu_op = OP_XOR;
      K_SRL, K_SRLI:   ctrl.alu_op = OP_SRL;
      K_SRA, K_SRAI:   ctrl.alu_op = OP_SRA;
      K_OR, K_ORI:     ctrl.alu_op = OP_OR;
      K_AND, K_ANDI:   ctrl.alu_op = OP_AND;

      ////////////////////////////////////////
      // multiply and divide
      ////////////////////////////////////////
      K_MUL:           ctrl.alu_op = OP_MUL;
      K_MULH:          ctrl.alu_op = OP_MULH;
      K_MULHSU:        ctrl.alu_op = OP_MULHSU;
      K_MULHU:         ctrl.alu_op = OP_MULHU;
      K_DIV:           ctrl.alu_op = OP_DIV;
      K_DIVU:          ctrl.alu_op = OP_DIVU;
      K_REM:           ctrl.alu_op = OP_REM;
      K_REMU:          ctrl.alu_op = OP_REMU;

      // upper immediate passes straight through
      K_LUI:           ctrl.alu_op = OP_LUI;

      // address and target adds
      K_LB, K_LH, K_LW, K_LBU, K_LHU,
      K_SB, K_SH, K_SW,
      K_BEQ, K_BNE, K_BLT, K_BGE, K_BLTU, K_BGEU,
      K_JAL, K_JALR, K_AUIPC: begin
        ctrl.alu_op = OP_ADD;
      end

      default:         ctrl.alu_op = OP_ADD;
    endcase
  end

endmodule

`default_nettype wire

/* source/datapath_ctrl_decode.sv */
// Datapath control decoder
`timescale 1ns/1ps
`default_nettype none

module datapath_ctrl_decode (
  input  decode_pkg::inst_kind_e kind_i,
  decode_ctrl_if.datapath        ctrl
);
  import decode_pkg::*;

  always_comb begin
    // start from the idle row and let each kind override what it needs
    ctrl.pc_sel     = CTRL_IDLE.pc_sel;
    ctrl.imm_sel    = CTRL_IDLE.imm_sel;
    ctrl.in1_sel    = CTRL_IDLE.in1_sel;
    ctrl.in2_imm    = CTRL_IDLE.in2_imm;
    ctrl.result_src = CTRL_IDLE.result_src;
    ctrl.rw_size    = CTRL_IDLE.rw_size;
    ctrl.ld_sign    = CTRL_IDLE.ld_sign;
    ctrl.rf_wr_en   = CTRL_IDLE.rf_wr_en;
    ctrl.mem_wr_en  = CTRL_IDLE.mem_wr_en;

    case (kind_i)
      K_ADD, K_SUB, K_SLL, K_SLT, K_SLTU, K_XOR, K_SRL, K_SRA, K_OR, K_AND,
      K_MUL, K_MULH, K_MULHSU, K_MULHU, K_DIV, K_DIVU, K_REM, K_REMU: begin
        ctrl.rf_wr_en = 1'b1;
      end
      K_ADDI, K_SLTI, K_SLTIU, K_XORI, K_ORI, K_ANDI: begin
        ctrl.rf_wr_en = 1'b1;
        ctrl.in2_imm  = 1'b1;
        ctrl.imm_sel  = I_IMM;
      end
      // shift amount is unsigned
      K_SLLI, K_SRLI, K_SRAI: begin
        ctrl.rf_wr_en = 1'b1;
        ctrl.in2_imm  = 1'b1;
        ctrl.imm_sel  = I_USIMM;
      end

      ////////////////////////////////////////
      // memory access
      ////////////////////////////////////////
      K_LB, K_LH, K_LW, K_LBU, K_LHU: begin
        ctrl.rf_wr_en   = 1'b1;
        ctrl.in2_imm    = 1'b1;
        ctrl.imm_sel    = I_IMM;
        ctrl.result_src = RES_MEM;
        ctrl.ld_sign    = (kind_i == K_LB) || (kind_i == K_LH);
        case (kind_i)
          K_LB, K_LBU: ctrl.rw_size = BYTE;
          K_LH, K_LHU: ctrl.rw_size = HALF_WORD;
          default:     ctrl.rw_size = WORD;
        endcase
      end
      K_SB, K_SH, K_SW: begin
        ctrl.mem_wr_en = 1'b1;
        ctrl.in2_imm   = 1'b1;
        ctrl.imm_sel   = S_IMM;
        case (kind_i)
          K_SB:    ctrl.rw_size = BYTE;
          K_SH:    ctrl.rw_size = HALF_WORD;
          default: ctrl.rw_size = WORD;
        endcase
      end

      ////////////////////////////////////////
      // control transfer and upper imm
      ////////////////////////////////////////
      K_BEQ, K_BNE, K_BLT, K_BGE, K_BLTU, K_BGEU: begin
        ctrl.imm_sel = B_IMM;
        case (kind_i)
          K_BEQ:   ctrl.pc_sel = BEQ;
          K_BNE:   ctrl.pc_sel = BNE;
          K_BLT:   ctrl.pc_sel = BLT;
          K_BGE:   ctrl.pc_sel = BGE;
          K_BLTU:  ctrl.pc_sel = BLTU;
          default: ctrl.pc_sel = BGEU;
        endcase
      end
      K_JAL: begin
        ctrl.rf_wr_en   = 1'b1;
        ctrl.imm_sel    = J_IMM;
        ctrl.result_src = RES_PC4;
        ctrl.pc_sel     = JAL;
      end
      K_JALR: begin
        ctrl.rf_wr_en   = 1'b1;
        ctrl.imm_sel    = I_IMM;
        ctrl.in2_imm    = 1'b1;
        ctrl.in1_sel    = IN1_PC_JALR;
        ctrl.result_src = RES_PC4;
        ctrl.pc_sel     = JALR;
      end
      K_AUIPC: begin
        ctrl.rf_wr_en = 1'b1;
        ctrl.imm_sel  = U_IMM;
        ctrl.in2_imm  = 1'b1;
        ctrl.in1_sel  = IN1_PC;
      end
      K_LUI: begin
        ctrl.rf_wr_en = 1'b1;
        ctrl.imm_sel  = U_IMM;
        ctrl.in2_imm  = 1'b1;
      end
      // ecall, ebreak and unknown keep the idle row
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* source/decode_stage_reg.sv */
// Decode stage register
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  input  logic              stall_i,
  decode_ctrl_if.stage      ctrl,
  output logic              valid_o,
  output decode_pkg::ctrl_t ctrl_o
);
  import decode_pkg::*;

  ctrl_t ctrl_d;
  ctrl_t ctrl_q;
  logic  valid_q;

  // invalid slots load a bubble
  always_comb begin
    ctrl_d = CTRL_IDLE;
    if (valid_i) begin
      ctrl_d.alu_op     = ctrl.alu_op;
      ctrl_d.pc_sel     = ctrl.pc_sel;
      ctrl_d.imm_sel    = ctrl.imm_sel;
      ctrl_d.in1_sel    = ctrl.in1_sel;
      ctrl_d.in2_imm    = ctrl.in2_imm;
      ctrl_d.result_src = ctrl.result_src;
      ctrl_d.rw_size    = ctrl.rw_size;
      ctrl_d.ld_sign    = ctrl.ld_sign;
      ctrl_d.rf_wr_en   = ctrl.rf_wr_en;
      ctrl_d.mem_wr_en  = ctrl.mem_wr_en;
      ctrl_d.exc        = ctrl.exc;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      ctrl_q  <= CTRL_IDLE;
    end else if (!stall_i) begin
      valid_q <= valid_i;
      ctrl_q  <= ctrl_d;
    end
  end

  assign valid_o = valid_q;
  assign ctrl_o  = ctrl_q;

endmodule

`default_nettype wire

/* source/decode_top.sv */
// RV32IM decode stage
`timescale 1ns/1ps
`default_nettype none

module decode_top (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    inst_valid_i,
  input  logic [31:0]             inst_i,
  input  logic                    stall_i,
  output logic                    ctrl_valid_o,
  output decode_pkg::alu_op_e     alu_op_o,
  output decode_pkg::pc_sel_e     pc_sel_o,
  output decode_pkg::imm_sel_e    imm_sel_o,
  output decode_pkg::in1_sel_e    in1_sel_o,
  output logic                    in2_imm_o,
  output decode_pkg::result_src_e result_src_o,
  output decode_pkg::rw_size_e    rw_size_o,
  output logic                    ld_sign_o,
  output logic                    rf_wr_en_o,
  output logic                    mem_wr_en_o,
  output decode_pkg::exc_e        exc_o
);
  import decode_pkg::*;

  inst_t      inst;
  inst_kind_e kind;
  ctrl_t      ctrl_q;

  decode_ctrl_if ctrl_if ();

  assign inst = inst_t'(inst_i);

  ////////////////////////////////////////
  // combinational decode
  ////////////////////////////////////////
  inst_classify u_classify (
    .inst_i (inst),
    .kind_o (kind),
    .ctrl   (ctrl_if.classify)
  );

  alu_op_decode u_alu_op (
    .kind_i (kind),
    .ctrl   (ctrl_if.alu)
  );

  datapath_ctrl_decode u_datapath (
    .kind_i (kind),
    .ctrl   (ctrl_if.datapath)
  );

  // one cycle from inst_i to the outputs
  decode_stage_reg u_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (inst_valid_i),
    .stall_i  (stall_i),
    .ctrl     (ctrl_if.stage),
    .valid_o  (ctrl_valid_o),
    .ctrl_o   (ctrl_q)
  );

  // unpack to flat outputs
  assign alu_op_o     = ctrl_q.alu_op;
  assign pc_sel_o     = ctrl_q.pc_sel;
  assign imm_sel_o    = ctrl_q.imm_sel;
  assign in1_sel_o    = ctrl_q.in1_sel;
  assign in2_imm_o    = ctrl_q.in2_imm;
  assign result_src_o = ctrl_q.result_src;
  assign rw_size_o    = ctrl_q.rw_size;
  assign ld_sign_o    = ctrl_q.ld_sign;
  assign rf_wr_en_o   = ctrl_q.rf_wr_en;
  assign mem_wr_en_o  = ctrl_q.mem_wr_en;
  assign exc_o        = ctrl_q.exc;

endmodule

`default_nettype wire

/* testbench/decode_tb_vectors.svh */
// Decode stage test vectors
`ifndef DECODE_TB_VECTORS_SVH
`define DECODE_TB_VECTORS_SVH

// each row holds the word, valid, stall, expected ctrl_valid_o and expected controls
typedef struct packed {
  logic [31:0] inst;
  logic        valid;
  logic        stall;
  logic        exp_valid;
  ctrl_t       exp_ctrl;
} vec_t;

vec_t vecs [$];

task automatic add_vec(input logic [31:0] inst, input logic valid, input logic stall,
                       input logic exp_valid, input ctrl_t exp_ctrl);
  vec_t v;
  v.inst      = inst;
  v.valid     = valid;
  v.stall     = stall;
  v.exp_valid = exp_valid;
  v.exp_ctrl  = exp_ctrl;
  vecs.push_back(v);
endtask

task automatic build_vectors();
  // add sub sll slt sltu xor srl sra or and with rd x1 rs1 x2 rs2 x3
  add_vec(32'h003100B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_ADD));
  add_vec(32'h403100B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_SUB));
  add_vec(32'h003110B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_SLL));
  add_vec(32'h003120B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_SLT));
  add_vec(32'h003130B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_SLTU));
  add_vec(32'h003140B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_XOR));
  add_vec(32'h003150B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_SRL));
  add_vec(32'h403150B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_SRA));
  add_vec(32'h003160B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_OR));
  add_vec(32'h003170B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_AND));

  // RV32M uses funct7 = 1
  add_vec(32'h023100B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_MUL));
  add_vec(32'h023110B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_MULH));
  add_vec(32'h023120B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_MULHSU));
  add_vec(32'h023130B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_MULHU));
  add_vec(32'h023140B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_DIV));
  add_vec(32'h023150B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_DIVU));
  add_vec(32'h023160B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_REM));
  add_vec(32'h023170B3, 1'b1, 1'b0, 1'b1, reg_alu_ctrl(OP_REMU));

  // addi slti sltiu xori ori andi with imm 5 then shifts by 3
  add_vec(32'h00510093, 1'b1, 1'b0, 1'b1, imm_alu_ctrl(OP_ADD, I_IMM));
  add_vec(32'h00512093, 1'b1, 1'b0, 1'b1, imm_alu_ctrl(OP_SLT, I_IMM));
  add_vec(32'h00513093, 1'b1, 1'b0, 1'b1, imm_alu_ctrl(OP_SLTU, I_IMM));
  add_vec(32'h00514093, 1'b1, 1'b0, 1'b1, imm_alu_ctrl(OP_XOR, I_IMM));
  add_vec(32'h00516093, 1'b1, 1'b0, 1'b1, imm_alu_ctrl(OP_OR, I_IMM));
  add_vec(32'h00517093, 1'b1, 1'b0, 1'b1, imm_alu_ctrl(OP_AND, I_IMM));
  add_vec(32'h00311093, 1'b1, 1'b0, 1'b1, imm_alu_ctrl(OP_SLL, I_USIMM));
  add_vec(32'h00315093, 1'b1, 1'b0, 1'b1, imm_alu_ctrl(OP_SRL, I_USIMM));
  add_vec(32'h40315093, 1'b1, 1'b0, 1'b1, imm_alu_ctrl(OP_SRA, I_USIMM));

  // shifts with bit 25 set
  add_vec(32'h02311093, 1'b1, 1'b0, 1'b1,
          with_exc(imm_alu_ctrl(OP_SLL, I_USIMM), ILLEGAL_INSTRUCTION));
  add_vec(32'h02315093, 1'b1, 1'b0, 1'b1,
          with_exc(imm_alu_ctrl(OP_SRL, I_USIMM), ILLEGAL_INSTRUCTION));
  add_vec(32'h42315093, 1'b1, 1'b0, 1'b1,
          with_exc(imm_alu_ctrl(OP_SRA, I_USIMM), ILLEGAL_INSTRUCTION));

  // lb lh lw lbu lhu then sb sh sw at offset 8
  add_vec(32'h00810083, 1'b1, 1'b0, 1'b1, load_ctrl(BYTE, 1'b1));
  add_vec(32'h00811083, 1'b1, 1'b0, 1'b1, load_ctrl(HALF_WORD, 1'b1));
  add_vec(32'h00812083, 1'b1, 1'b0, 1'b1, load_ctrl(WORD, 1'b0));
  add_vec(32'h00814083, 1'b1, 1'b0, 1'b1, load_ctrl(BYTE, 1'b0));
  add_vec(32'h00815083, 1'b1, 1'b0, 1'b1, load_ctrl(HALF_WORD, 1'b0));
  add_vec(32'h00310423, 1'b1, 1'b0, 1'b1, store_ctrl(BYTE));
  add_vec(32'h00311423, 1'b1, 1'b0, 1'b1, store_ctrl(HALF_WORD));
  add_vec(32'h00312423, 1'b1, 1'b0, 1'b1, store_ctrl(WORD));

  // beq bne blt bge bltu bgeu
  add_vec(32'h00310463, 1'b1, 1'b0, 1'b1, branch_ctrl(BEQ));
  add_vec(32'h00311463, 1'b1, 1'b0, 1'b1, branch_ctrl(BNE));
  add_vec(32'h00314463, 1'b1, 1'b0, 1'b1, branch_ctrl(BLT));
  add_vec(32'h00315463, 1'b1, 1'b0, 1'b1, branch_ctrl(BGE));
  add_vec(32'h00316463, 1'b1, 1'b0, 1'b1, branch_ctrl(BLTU));
  add_vec(32'h00317463, 1'b1, 1'b0, 1'b1, branch_ctrl(BGEU));

  // jal jalr auipc lui
  add_vec(32'h010000EF, 1'b1, 1'b0, 1'b1, link_ctrl(JAL, J_IMM, IN1_RS1, 1'b0));
  add_vec(32'h004100E7, 1'b1, 1'b0, 1'b1, link_ctrl(JALR, I_IMM, IN1_PC_JALR, 1'b1));
  add_vec(32'h12345097, 1'b1, 1'b0, 1'b1, upper_ctrl(OP_ADD, IN1_PC));
  add_vec(32'h123450B7, 1'b1, 1'b0, 1'b1, upper_ctrl(OP_LUI, IN1_RS1));

  // ecall, ebreak and a custom-0 opcode
  add_vec(32'h00000073, 1'b1, 1'b0, 1'b1, with_exc(CTRL_IDLE, ECALL));
  add_vec(32'h00100073, 1'b1, 1'b0, 1'b1, with_exc(CTRL_IDLE, EBREAK));
  add_vec(32'h0000000B, 1'b1, 1'b0, 1'b1, CTRL_IDLE);

  // invalid slot loads a bubble and a stall then keeps it
  add_vec(32'h023100B3, 1'b0, 1'b0, 1'b0, CTRL_IDLE);
  add_vec(32'h00312423, 1'b1, 1'b1, 1'b0, CTRL_IDLE);

  // sw loaded then held over three stalled slots
  add_vec(32'h00312423, 1'b1, 1'b0, 1'b1, store_ctrl(WORD));
  add_vec(32'h003100B3, 1'b1, 1'b1, 1'b1, store_ctrl(WORD));
  add_vec(32'h00100073, 1'b0, 1'b1, 1'b1, store_ctrl(WORD));
  add_vec(32'h00810083, 1'b1, 1'b1, 1'b1, store_ctrl(WORD));
  add_vec(32'h00100073, 1'b1, 1'b0, 1'b1, with_exc(CTRL_IDLE, EBREAK));
endtask

`endif

/* testbench/decode_tb.sv */
// Decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module decode_tb;
  import decode_pkg::*;

  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_MARGIN = 20;

  logic        clk_i;
  logic        arst_n_i;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic        stall_i;
  logic        ctrl_valid_o;
  alu_op_e     alu_op_o;
  pc_sel_e     pc_sel_o;
  imm_sel_e    imm_sel_o;
  in1_sel_e    in1_sel_o;
  logic        in2_imm_o;
  result_src_e result_src_o;
  rw_size_e    rw_size_o;
  logic        ld_sign_o;
  logic        rf_wr_en_o;
  logic        mem_wr_en_o;
  exc_e        exc_o;
  ctrl_t       dut_ctrl;
  int          cycle_cnt = 0;

  decode_top dut0 (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .stall_i      (stall_i),
    .ctrl_valid_o (ctrl_valid_o),
    .alu_op_o     (alu_op_o),
    .pc_sel_o     (pc_sel_o),
    .imm_sel_o    (imm_sel_o),
    .in1_sel_o    (in1_sel_o),
    .in2_imm_o    (in2_imm_o),
    .result_src_o (result_src_o),
    .rw_size_o    (rw_size_o),
    .ld_sign_o    (ld_sign_o),
    .rf_wr_en_o   (rf_wr_en_o),
    .mem_wr_en_o  (mem_wr_en_o),
    .exc_o        (exc_o)
  );

  // flat outputs gathered back into one struct
  assign dut_ctrl = '{
    alu_op:     alu_op_o,
    pc_sel:     pc_sel_o,
    imm_sel:    imm_sel_o,
    in1_sel:    in1_sel_o,
    in2_imm:    in2_imm_o,
    result_src: result_src_o,
    rw_size:    rw_size_o,
    ld_sign:    ld_sign_o,
    rf_wr_en:   rf_wr_en_o,
    mem_wr_en:  mem_wr_en_o,
    exc:        exc_o
  };

  ////////////////////////////////////////
  // expected control rows
  ////////////////////////////////////////

  function automatic ctrl_t reg_alu_ctrl(input alu_op_e op);
    ctrl_t c;
    c          = CTRL_IDLE;
    c.alu_op   = op;
    c.rf_wr_en = 1'b1;
    return c;
  endfunction

  function automatic ctrl_t imm_alu_ctrl(input alu_op_e op, input imm_sel_e imm);
    ctrl_t c;
    c         = reg_alu_ctrl(op);
    c.in2_imm = 1'b1;
    c.imm_sel = imm;
    return c;
  endfunction

  function automatic ctrl_t load_ctrl(input rw_size_e size, input logic sign);
    ctrl_t c;
    c            = imm_alu_ctrl(OP_ADD, I_IMM);
    c.result_src = RES_MEM;
    c.rw_size    = size;
    c.ld_sign    = sign;
    return c;
  endfunction

  function automatic ctrl_t store_ctrl(input rw_size_e size);
    ctrl_t c;
    c           = CTRL_IDLE;
    c.mem_wr_en = 1'b1;
    c.in2_imm   = 1'b1;
    c.imm_sel   = S_IMM;
    c.rw_size   = size;
    return c;
  endfunction

  function automatic ctrl_t branch_ctrl(input pc_sel_e pc);
    ctrl_t c;
    c         = CTRL_IDLE;
    c.imm_sel = B_IMM;
    c.pc_sel  = pc;
    return c;
  endfunction

  // jumps write pc + 4 back
  function automatic ctrl_t link_ctrl(input pc_sel_e pc, input imm_sel_e imm,
                                      input in1_sel_e in1, input logic in2);
    ctrl_t c;
    c            = reg_alu_ctrl(OP_ADD);
    c.pc_sel     = pc;
    c.imm_sel    = imm;
    c.in1_sel    = in1;
    c.in2_imm    = in2;
    c.result_src = RES_PC4;
    return c;
  endfunction

  function automatic ctrl_t upper_ctrl(input alu_op_e op, input in1_sel_e in1);
    ctrl_t c;
    c         = imm_alu_ctrl(op, U_IMM);
    c.in1_sel = in1;
    return c;
  endfunction

  function automatic ctrl_t with_exc(input ctrl_t base, input exc_e exc);
    ctrl_t c;
    c     = base;
    c.exc = exc;
    return c;
  endfunction

  `include "decode_tb_vectors.svh"

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic compare_field(input string name, input logic [4:0] got,
                               input logic [4:0] exp, input string where);
    if (got !== exp) begin
      $display("MISMATCH %s at %s: got 0x%h expected 0x%h", name, where, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_valid(input logic got, input logic exp, input string where);
    compare_field("ctrl_valid_o", 5'(got), 5'(exp), where);
  endtask

  task automatic check_ctrl(input ctrl_t got, input ctrl_t exp, input string where);
    compare_field("alu_op_o", 5'(got.alu_op), 5'(exp.alu_op), where);
    compare_field("pc_sel_o", 5'(got.pc_sel), 5'(exp.pc_sel), where);
    compare_field("imm_sel_o", 5'(got.imm_sel), 5'(exp.imm_sel), where);
    compare_field("in1_sel_o", 5'(got.in1_sel), 5'(exp.in1_sel), where);
    compare_field("in2_imm_o", 5'(got.in2_imm), 5'(exp.in2_imm), where);
    compare_field("result_src_o", 5'(got.result_src), 5'(exp.result_src), where);
    compare_field("rw_size_o", 5'(got.rw_size), 5'(exp.rw_size), where);
    compare_field("ld_sign_o", 5'(got.ld_sign), 5'(exp.ld_sign), where);
    compare_field("rf_wr_en_o", 5'(got.rf_wr_en), 5'(exp.rf_wr_en), where);
    compare_field("mem_wr_en_o", 5'(got.mem_wr_en), 5'(exp.mem_wr_en), where);
    compare_field("exc_o", 5'(got.exc), 5'(exp.exc), where);
  endtask

  task automatic check_row(input vec_t v, input int idx);
    string where;
    where = $sformatf("row %0d", idx);
    check_valid(ctrl_valid_o, v.exp_valid, where);
    check_ctrl(dut_ctrl, v.exp_ctrl, where);
  endtask

  ////////////////////////////////////////
  // clock, timeout and stimulus
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= RESET_CYCLES + vecs.size() + TIMEOUT_MARGIN) begin
      $display("timeout: the test did not finish after %0d cycles", cycle_cnt);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  initial begin
    arst_n_i     = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    stall_i      = 1'b0;
    build_vectors();

    repeat (RESET_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_valid(ctrl_valid_o, 1'b0, "reset");
    check_ctrl(dut_ctrl, CTRL_IDLE, "reset");

    // row i is driven while row i-1 shows at the outputs
    for (int i = 0; i < vecs.size(); i++) begin
      @(posedge clk_i);
      inst_i       <= vecs[i].inst;
      inst_valid_i <= vecs[i].valid;
      stall_i      <= vecs[i].stall;
      if (i > 0) begin
        @(negedge clk_i);
        check_row(vecs[i-1], i - 1);
      end
    end

    @(posedge clk_i);
    inst_valid_i <= 1'b0;
    stall_i      <= 1'b0;
    @(negedge clk_i);
    check_row(vecs[vecs.size()-1], vecs.size() - 1);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+testbench
source/decode_pkg.sv
source/decode_ctrl_if.sv
source/inst_classify.sv
source/alu_op_decode.sv
source/datapath_ctrl_decode.sv
source/decode_stage_reg.sv
source/decode_top.sv
testbench/decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module decode_tb -Mdir obj_dir -f sources.f \
  || { echo "build failed"; exit 1; }

./obj_dir/Vdecode_tb > sim.log 2>&1
cat sim.log

grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
